// File: vlog.f
+incdir+src
src/croc_lite_pkg.sv
src/bus_demux.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/gpio_regs.sv
src/resp_mux.sv
src/croc_lite_domain.sv
sim/croc_lite_props.sv
sim/tb_croc_lite.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_croc_lite
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_croc_lite.sv
// Fills the whole SRAM before any read since its reset contents are undefined; needs --timing
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module tb_croc_lite import croc_lite_pkg::*; ();

  localparam int sram_words  = `CROC_SRAM_WORDS;
  localparam int rand_writes = 150;
  localparam int misc_cycles = 200;
  // Fill, partial writes and read back, plus the register tests, with margin
  localparam int cycle_limit = 4 * (2 * sram_words + rand_writes + misc_cycles);
  localparam logic [31:0] ctrl_base = `CROC_SOCCTRL_BASE;
  localparam logic [31:0] gpio_base = `CROC_GPIO_BASE;

  typedef struct packed {
    logic                    err;
    logic [`CROC_DATA_W-1:0] rdata;
  } exp_rsp_t;

  logic                        clk;
  logic                        reset;
  logic                        fetch_en;
  obi_req_t                    req;
  obi_rsp_t                    rsp;
  logic [`CROC_GPIO_COUNT-1:0] gpio_in;
  logic [`CROC_GPIO_COUNT-1:0] gpio_out;
  logic [`CROC_GPIO_COUNT-1:0] gpio_oe;
  logic [`CROC_GPIO_COUNT-1:0] gpio_sync;
  logic [`CROC_ADDR_W-1:0]     boot_addr;
  logic                        fetch_enable;

  // Reference model
  logic [`CROC_DATA_W-1:0]     sram_model [sram_words];
  logic [`CROC_ADDR_W-1:0]     boot_model;
  logic [`CROC_GPIO_COUNT-1:0] out_model;
  logic [`CROC_GPIO_COUNT-1:0] oe_model;
  exp_rsp_t                    exp_q [$];
  string                       name_q [$];
  logic [31:0]                 seed = 32'd96;
  int                          cycles = 0;

  croc_lite_domain u_dut (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .fetch_en_i     ( fetch_en     ),
    .obi_req_i      ( req          ),
    .gpio_i         ( gpio_in      ),
    .obi_rsp_o      ( rsp          ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_oe      ),
    .gpio_in_sync_o ( gpio_sync    ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] sram_addr(input int idx);
    return `CROC_SRAM_BASE + (32'(idx) << 2);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    assert (act_v === exp_v)
      else abort_run($sformatf("ERR %s expected %0h actual %0h", name, exp_v, act_v));
  endtask

  // ------------------------------------------------------------------
  // Bus stimulus, one request per rising edge
  // ------------------------------------------------------------------
  task automatic issue(input string name, input logic we, input logic [3:0] be,
                       input logic [31:0] addr, input logic [31:0] wdata,
                       input exp_rsp_t exp_r);
    @(posedge clk);
    req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    exp_q.push_back(exp_r);
    name_q.push_back(name);
  endtask

  task automatic bus_write(input string name, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, input logic err);
    issue(name, 1'b1, be, addr, wdata, '{err: err, rdata: err ? `CROC_ERR_DATA : 32'd0});
  endtask

  task automatic bus_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_data, input logic err);
    issue(name, 1'b0, 4'hF, addr, 32'd0, '{err: err, rdata: exp_data});
  endtask

  // Stop requesting and wait for every response
  task automatic finish_burst();
    @(posedge clk);
    req <= '0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Responses are sampled on the falling edge, away from register updates
  always @(negedge clk) begin : check_rsp
    exp_rsp_t e;
    string    n;
    if (!reset && rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        abort_run("Response arrived with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        expect_eq(n, 64'(e), 64'({rsp.err, rsp.rdata}));
      end
    end
  end

  always @(negedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles", cycles));
    end else if (u_dut.u_props.fail_count != 0) begin
      abort_run("Bound protocol assertion failed");
    end
  end

  initial begin
    logic [31:0] data;
    logic [31:0] rnd;
    logic [3:0]  be;
    int          idx;
    reset    = 1'b1;
    fetch_en = 1'b0;
    req      = '0;
    gpio_in  = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expect_eq("reset_rvalid", 64'd0, 64'(rsp.rvalid));
    expect_eq("reset_boot_addr", 64'(`CROC_SRAM_BASE), 64'(boot_addr));
    expect_eq("reset_fetch_enable", 64'd0, 64'(fetch_enable));
    expect_eq("reset_gpio_o", 64'd0, 64'(gpio_out));
    expect_eq("reset_gpio_out_en", 64'd0, 64'(gpio_oe));

    // ------------------------------------------------------------------
    // SRAM fill, partial writes, read back
    // ------------------------------------------------------------------
    for (int i = 0; i < sram_words; i++) begin
      data = next_rand();
      sram_model[i] = data;
      bus_write("sram_fill", sram_addr(i), 4'hF, data, 1'b0);
    end
    for (int i = 0; i < rand_writes; i++) begin
      rnd  = next_rand();
      idx  = int'(rnd[23:16]) % sram_words;
      be   = rnd[27:24];
      data = next_rand();
      sram_model[idx] = merge_bytes(sram_model[idx], data, be);
      bus_write("sram_be_write", sram_addr(idx), be, data, 1'b0);
    end
    for (int i = 0; i < sram_words; i++) begin
      bus_read("sram_read", sram_addr(i), sram_model[i], 1'b0);
    end
    finish_burst();

    // Unmapped space, just past the SRAM window and between the register windows
    bus_read("unmapped_read", 32'h2000_0000, `CROC_ERR_DATA, 1'b1);
    bus_write("unmapped_write", `CROC_SRAM_BASE + 32'h400, 4'hF, next_rand(), 1'b1);
    bus_write("unmapped_write_gap", ctrl_base + 32'h1000, 4'hF, next_rand(), 1'b1);
    bus_read("sram_after_unmapped", sram_addr(0), sram_model[0], 1'b0);
    finish_burst();
    expect_eq("boot_after_unmapped", 64'(`CROC_SRAM_BASE), 64'(boot_addr));

    // ------------------------------------------------------------------
    // Control block
    // ------------------------------------------------------------------
    boot_model = `CROC_SRAM_BASE;
    bus_read("boot_reset_read", ctrl_base, boot_model, 1'b0);
    data = next_rand();
    boot_model = merge_bytes(boot_model, data, 4'b0101);
    bus_write("boot_write", ctrl_base, 4'b0101, data, 1'b0);
    bus_read("boot_read", ctrl_base, boot_model, 1'b0);
    bus_read("ctrl_hole_read", ctrl_base + 32'h800, 32'd0, 1'b0);
    finish_burst();
    expect_eq("boot_addr_o", 64'(boot_model), 64'(boot_addr));
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      fetch_en <= i[0];
      bus_write("fetch_reg_write", ctrl_base + 32'h4, 4'h1, {31'd0, i[1]}, 1'b0);
      bus_read("fetch_reg_read", ctrl_base + 32'h4, {31'd0, i[1]}, 1'b0);
      finish_burst();
      expect_eq("fetch_enable_o", 64'(i[1] | i[0]), 64'(fetch_enable));
    end

    // ------------------------------------------------------------------
    // GPIO block
    // ------------------------------------------------------------------
    data = next_rand();
    out_model = data[`CROC_GPIO_COUNT-1:0];
    bus_write("gpio_out_write", gpio_base + 32'h4, 4'hF, data, 1'b0);
    rnd = next_rand();
    oe_model = rnd[`CROC_GPIO_COUNT-1:0];
    bus_write("gpio_oe_write", gpio_base + 32'h8, 4'hF, rnd, 1'b0);
    // Lane 0 disabled, so the pins keep their enables
    bus_write("gpio_oe_be_write", gpio_base + 32'h8, 4'hE, next_rand(), 1'b0);
    bus_read("gpio_out_read", gpio_base + 32'h4, 32'(out_model), 1'b0);
    bus_read("gpio_oe_read", gpio_base + 32'h8, 32'(oe_model), 1'b0);
    finish_burst();
    expect_eq("gpio_o", 64'(out_model), 64'(gpio_out));
    expect_eq("gpio_out_en_o", 64'(oe_model), 64'(gpio_oe));
    rnd = next_rand();
    @(posedge clk);
    gpio_in <= rnd[`CROC_GPIO_COUNT-1:0];
    repeat (3) @(posedge clk);
    @(negedge clk);
    expect_eq("gpio_in_sync_o", 64'(rnd[`CROC_GPIO_COUNT-1:0]), 64'(gpio_sync));
    bus_read("gpio_in_read", gpio_base, 32'(rnd[`CROC_GPIO_COUNT-1:0]), 1'b0);
    finish_burst();

    // Back to back across all targets
    data = next_rand();
    bus_read("mix_sram", sram_addr(5), sram_model[5], 1'b0);
    bus_read("mix_ctrl", ctrl_base, boot_model, 1'b0);
    bus_read("mix_gpio", gpio_base + 32'h4, 32'(out_model), 1'b0);
    bus_read("mix_err", 32'h0400_0000, `CROC_ERR_DATA, 1'b1);
    sram_model[7] = data;
    bus_write("mix_sram_write", sram_addr(7), 4'hF, data, 1'b0);
    bus_read("mix_sram_after", sram_addr(7), sram_model[7], 1'b0);
    finish_burst();

    repeat (2) @(posedge clk);
    @(negedge clk);
    if (u_dut.u_props.fail_count != 0) begin
      abort_run("Bound protocol assertion failed");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/croc_lite_props.sv
// Checks handshake timing of the single manager port only; data is checked by the testbench
`timescale 1ns/1ps
`default_nettype none

module croc_lite_props import croc_lite_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input obi_req_t req_i,
  input obi_rsp_t rsp_i
);

  int unsigned fail_count = 0;

  // All targets grant in the request cycle
  a_gnt_is_req: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_i.gnt == req_i.req)
    else begin
      $error("gnt does not follow req");
      fail_count++;
    end

  a_rvalid_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.req |=> rsp_i.rvalid)
    else begin
      $error("accepted request got no rvalid one cycle later");
      fail_count++;
    end

  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_i.rvalid |-> $past(req_i.req))
    else begin
      $error("rvalid without a request in the previous cycle");
      fail_count++;
    end

  // Nothing pending when reset is released
  a_idle_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !rsp_i.rvalid)
    else begin
      $error("rvalid high right after reset");
      fail_count++;
    end

endmodule

bind croc_lite_domain croc_lite_props u_props (
  .clk_i   ( clk_i     ),
  .reset_i ( reset_i   ),
  .req_i   ( obi_req_i ),
  .rsp_i   ( obi_rsp_o )
);

`default_nettype wire

// File: src/croc_lite_domain.sv
// One manager, always granted; responses come one cycle after acceptance and cannot be stalled
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module croc_lite_domain (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_en_i,
  input  croc_lite_pkg::obi_req_t     obi_req_i,
  input  logic [`CROC_GPIO_COUNT-1:0] gpio_i,
  output croc_lite_pkg::obi_rsp_t     obi_rsp_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_in_sync_o,
  output logic [`CROC_ADDR_W-1:0]     boot_addr_o,
  output logic                        fetch_enable_o
);

  // ------------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------------
  logic                      gnt;
  logic                      sram_sel;
  logic                      ctrl_sel;
  logic                      gpio_sel;
  logic                      we;
  logic [`CROC_DATA_W/8-1:0] be;
  logic [9:0]                offset;
  logic [`CROC_DATA_W-1:0]   wdata;

  // Response stage
  croc_lite_pkg::target_e  rsp_tgt;
  logic                    rsp_read;
  logic                    rsp_valid;
  logic [`CROC_DATA_W-1:0] sram_rdata;
  logic [`CROC_DATA_W-1:0] ctrl_rdata;
  logic [`CROC_DATA_W-1:0] gpio_rdata;

  bus_demux i_bus_demux (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .req_i       ( obi_req_i ),
    .gnt_o       ( gnt       ),
    .sram_sel_o  ( sram_sel  ),
    .ctrl_sel_o  ( ctrl_sel  ),
    .gpio_sel_o  ( gpio_sel  ),
    .we_o        ( we        ),
    .be_o        ( be        ),
    .offset_o    ( offset    ),
    .wdata_o     ( wdata     ),
    .rsp_tgt_o   ( rsp_tgt   ),
    .rsp_read_o  ( rsp_read  ),
    .rsp_valid_o ( rsp_valid )
  );

  // ------------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------------
  sram_bank i_sram_bank (
    .clk_i       ( clk_i       ),
    .sel_i       ( sram_sel    ),
    .we_i        ( we          ),
    .be_i        ( be          ),
    .word_addr_i ( offset[9:2] ),
    .wdata_i     ( wdata       ),
    .rdata_o     ( sram_rdata  )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .sel_i          ( ctrl_sel       ),
    .we_i           ( we             ),
    .be_i           ( be             ),
    .offset_i       ( offset         ),
    .wdata_i        ( wdata          ),
    .fetch_en_i     ( fetch_en_i     ),
    .rdata_o        ( ctrl_rdata     ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o )
  );

  gpio_regs i_gpio (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .sel_i          ( gpio_sel       ),
    .we_i           ( we             ),
    .be_i           ( be             ),
    .offset_i       ( offset         ),
    .wdata_i        ( wdata          ),
    .gpio_i         ( gpio_i         ),
    .rdata_o        ( gpio_rdata     ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o )
  );

  // Response mux, also the error subordinate
  resp_mux i_resp_mux (
    .rsp_tgt_i    ( rsp_tgt    ),
    .rsp_read_i   ( rsp_read   ),
    .rsp_valid_i  ( rsp_valid  ),
    .sram_rdata_i ( sram_rdata ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .gpio_rdata_i ( gpio_rdata ),
    .gnt_i        ( gnt        ),
    .rsp_o        ( obi_rsp_o  )
  );

endmodule

`default_nettype wire

// File: src/resp_mux.sv
// Purely combinational; unmapped accesses answer err with a fixed pattern, writes answer zero
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module resp_mux import croc_lite_pkg::*; (
  input  target_e                 rsp_tgt_i,
  input  logic                    rsp_read_i,
  input  logic                    rsp_valid_i,
  input  logic [`CROC_DATA_W-1:0] sram_rdata_i,
  input  logic [`CROC_DATA_W-1:0] ctrl_rdata_i,
  input  logic [`CROC_DATA_W-1:0] gpio_rdata_i,
  input  logic                    gnt_i,
  output obi_rsp_t                rsp_o
);

  logic [`CROC_DATA_W-1:0] tgt_data;
  logic                    is_err;

  // Target that answers this cycle
  always_comb begin
    case (rsp_tgt_i)
      TGT_SRAM: tgt_data = sram_rdata_i;
      TGT_CTRL: tgt_data = ctrl_rdata_i;
      TGT_GPIO: tgt_data = gpio_rdata_i;
      TGT_ERR:  tgt_data = `CROC_ERR_DATA;
      default:  tgt_data = `CROC_ERR_DATA;
    endcase
  end

  assign is_err = rsp_tgt_i == TGT_ERR;

  // Error subordinate returns its pattern for reads and writes alike
  always_comb begin
    rsp_o.gnt    = gnt_i;
    rsp_o.rvalid = rsp_valid_i;
    rsp_o.err    = rsp_valid_i & is_err;
    rsp_o.rdata  = (rsp_read_i || is_err) ? tgt_data : '0;
  end

endmodule

`default_nettype wire

// File: src/gpio_regs.sv
// Inputs pass a two-flop synchronizer; output and enable registers clear on reset, no interrupts
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module gpio_regs import croc_lite_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        sel_i,
  input  logic                        we_i,
  input  logic [`CROC_DATA_W/8-1:0]   be_i,
  input  logic [9:0]                  offset_i,
  input  logic [`CROC_DATA_W-1:0]     wdata_i,
  input  logic [`CROC_GPIO_COUNT-1:0] gpio_i,
  output logic [`CROC_DATA_W-1:0]     rdata_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [`CROC_GPIO_COUNT-1:0] gpio_in_sync_o
);

  localparam int unsigned pad_w = `CROC_DATA_W - `CROC_GPIO_COUNT;

  logic [`CROC_GPIO_COUNT-1:0] out_q;
  logic [`CROC_GPIO_COUNT-1:0] oe_q;
  logic [`CROC_GPIO_COUNT-1:0] sync_q1;
  logic [`CROC_GPIO_COUNT-1:0] sync_q2;
  logic [`CROC_DATA_W-1:0]     out_word;
  logic [`CROC_DATA_W-1:0]     oe_word;
  logic [`CROC_DATA_W-1:0]     rdata_d;
  logic                        hit_in;
  logic                        hit_out;
  logic                        hit_oe;

  // Offsets 0x0 input, 0x4 output, 0x8 output enable
  assign hit_in  = offset_i[9:2] == 8'd0;
  assign hit_out = offset_i[9:2] == 8'd1;
  assign hit_oe  = offset_i[9:2] == 8'd2;

  assign out_word = apply_be({{pad_w{1'b0}}, out_q}, wdata_i, be_i);
  assign oe_word  = apply_be({{pad_w{1'b0}}, oe_q}, wdata_i, be_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      if (sel_i && we_i && hit_out) begin
        out_q <= out_word[`CROC_GPIO_COUNT-1:0];
      end
      if (sel_i && we_i && hit_oe) begin
        oe_q <= oe_word[`CROC_GPIO_COUNT-1:0];
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (hit_in) begin
      rdata_d = {{pad_w{1'b0}}, sync_q2};
    end else if (hit_out) begin
      rdata_d = {{pad_w{1'b0}}, out_q};
    end else if (hit_oe) begin
      rdata_d = {{pad_w{1'b0}}, oe_q};
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_o <= (sel_i && !we_i) ? rdata_d : '0;
  end

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = oe_q;
  assign gpio_in_sync_o = sync_q2;

endmodule

`default_nettype wire

// File: src/soc_ctrl_regs.sv
// Boot address resets to the SRAM base; the fetch enable pin can only force fetching on
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module soc_ctrl_regs import croc_lite_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      sel_i,
  input  logic                      we_i,
  input  logic [`CROC_DATA_W/8-1:0] be_i,
  input  logic [9:0]                offset_i,
  input  logic [`CROC_DATA_W-1:0]   wdata_i,
  input  logic                      fetch_en_i,
  output logic [`CROC_DATA_W-1:0]   rdata_o,
  output logic [`CROC_ADDR_W-1:0]   boot_addr_o,
  output logic                      fetch_enable_o
);

  logic [`CROC_ADDR_W-1:0] boot_addr_q;
  logic                    fetch_en_q;
  logic                    hit_boot;
  logic                    hit_fetch;
  logic [`CROC_DATA_W-1:0] rdata_d;

  // Word offsets 0x0 and 0x4
  assign hit_boot  = offset_i[9:2] == 8'd0;
  assign hit_fetch = offset_i[9:2] == 8'd1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_addr_q <= `CROC_SRAM_BASE;
      fetch_en_q  <= 1'b0;
    end else if (sel_i && we_i) begin
      if (hit_boot) begin
        boot_addr_q <= apply_be(boot_addr_q, wdata_i, be_i);
      end
      if (hit_fetch && be_i[0]) begin
        fetch_en_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (hit_boot) begin
      rdata_d = boot_addr_q;
    end else if (hit_fetch) begin
      rdata_d = {{(`CROC_DATA_W-1){1'b0}}, fetch_en_q};
    end
  end

  // Zero when not read, so idle offsets answer zero
  always_ff @(posedge clk_i) begin
    rdata_o <= (sel_i && !we_i) ? rdata_d : '0;
  end

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

`default_nettype wire

// File: src/sram_bank.sv
// Contents are undefined after reset; read data holds until the next selected read
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module sram_bank import croc_lite_pkg::*; (
  input  logic                               clk_i,
  input  logic                               sel_i,
  input  logic                               we_i,
  input  logic [`CROC_DATA_W/8-1:0]          be_i,
  input  logic [$clog2(`CROC_SRAM_WORDS)-1:0] word_addr_i,
  input  logic [`CROC_DATA_W-1:0]            wdata_i,
  output logic [`CROC_DATA_W-1:0]            rdata_o
);

  logic [`CROC_DATA_W-1:0] mem_q [`CROC_SRAM_WORDS];

  // Single port, write and read never in the same cycle
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        mem_q[word_addr_i] <= apply_be(mem_q[word_addr_i], wdata_i, be_i);
      end else begin
        rdata_o <= mem_q[word_addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bus_demux.sv
// Windows are aligned to their size; only the low 1 KiB of a register window reaches the registers
`timescale 1ns/1ps
`default_nettype none
`include "croc_lite_defines.svh"

module bus_demux import croc_lite_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  obi_req_t                  req_i,
  output logic                      gnt_o,
  output logic                      sram_sel_o,
  output logic                      ctrl_sel_o,
  output logic                      gpio_sel_o,
  output logic                      we_o,
  output logic [`CROC_DATA_W/8-1:0] be_o,
  output logic [9:0]                offset_o,
  output logic [`CROC_DATA_W-1:0]   wdata_o,
  output target_e                   rsp_tgt_o,
  output logic                      rsp_read_o,
  output logic                      rsp_valid_o
);

  localparam logic [`CROC_ADDR_W-1:0] sram_base = `CROC_SRAM_BASE;
  localparam logic [`CROC_ADDR_W-1:0] ctrl_base = `CROC_SOCCTRL_BASE;
  localparam logic [`CROC_ADDR_W-1:0] gpio_base = `CROC_GPIO_BASE;

  logic    sram_hit;
  logic    ctrl_hit;
  logic    gpio_hit;
  logic    low_kib;
  target_e tgt;

  // ------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------
  assign sram_hit = req_i.addr[`CROC_ADDR_W-1:10] == sram_base[`CROC_ADDR_W-1:10];
  assign ctrl_hit = req_i.addr[`CROC_ADDR_W-1:12] == ctrl_base[`CROC_ADDR_W-1:12];
  assign gpio_hit = req_i.addr[`CROC_ADDR_W-1:12] == gpio_base[`CROC_ADDR_W-1:12];
  // Upper part of a register window still answers, with zero
  assign low_kib  = req_i.addr[11:10] == 2'b00;

  always_comb begin
    tgt = TGT_ERR;
    if (sram_hit) begin
      tgt = TGT_SRAM;
    end else if (ctrl_hit) begin
      tgt = TGT_CTRL;
    end else if (gpio_hit) begin
      tgt = TGT_GPIO;
    end
  end

  // All targets take a request in the cycle it is presented
  assign gnt_o      = req_i.req;
  assign sram_sel_o = req_i.req & sram_hit;
  assign ctrl_sel_o = req_i.req & ctrl_hit & low_kib;
  assign gpio_sel_o = req_i.req & gpio_hit & low_kib;
  assign we_o       = req_i.we;
  assign be_o       = req_i.be;
  assign offset_o   = req_i.addr[9:0];
  assign wdata_o    = req_i.wdata;

  // ------------------------------------------------------------------
  // Response stage record
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
      rsp_tgt_o   <= TGT_ERR;
      rsp_read_o  <= 1'b0;
    end else begin
      rsp_valid_o <= req_i.req;
      if (req_i.req) begin
        rsp_tgt_o  <= tgt;
        rsp_read_o <= ~req_i.we;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/croc_lite_pkg.sv
// Single-manager bus types without transaction IDs; byte enables cover the full data word
`default_nettype none
`include "croc_lite_defines.svh"

package croc_lite_pkg;

  // Request channel, driven by the manager
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`CROC_DATA_W/8-1:0] be;
    logic [`CROC_ADDR_W-1:0]   addr;
    logic [`CROC_DATA_W-1:0]   wdata;
  } obi_req_t;

  // Response channel, gnt in the request cycle, the rest one cycle later
  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic                    err;
    logic [`CROC_DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef enum logic [1:0] {
    TGT_SRAM = 2'd0,
    TGT_CTRL = 2'd1,
    TGT_GPIO = 2'd2,
    TGT_ERR  = 2'd3
  } target_e;

  // Byte lane merge of write data into an old word
  function automatic logic [`CROC_DATA_W-1:0] apply_be(
    input logic [`CROC_DATA_W-1:0]   old_val,
    input logic [`CROC_DATA_W-1:0]   new_val,
    input logic [`CROC_DATA_W/8-1:0] be
  );
    logic [`CROC_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `CROC_DATA_W/8; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: src/croc_lite_defines.svh
// Address map and sizes shared by RTL and testbench; SRAM window is 1 KiB, register windows 4 KiB
`ifndef CROC_LITE_DEFINES_SVH
`define CROC_LITE_DEFINES_SVH

// Bus widths
`define CROC_ADDR_W 32
`define CROC_DATA_W 32

// SRAM bank, one window of CROC_SRAM_WORDS words
`define CROC_SRAM_WORDS 256
`define CROC_SRAM_BASE 32'h1000_0000

// Peripheral windows, 4 KiB each
`define CROC_SOCCTRL_BASE 32'h0300_0000
`define CROC_GPIO_BASE 32'h0300_5000

// Number of GPIO pins, at most the data width
`define CROC_GPIO_COUNT 8

// Read pattern of the error subordinate
`define CROC_ERR_DATA 32'hBADC_AB1E

`endif
